//--- hw/mazeRunner_defines.svh
`ifndef MAZE_RUNNER_DEFINES_SVH
`define MAZE_RUNNER_DEFINES_SVH

// Countdown before the robot starts to move
`define MAZE_COUNT_CYCLES 40

// Pause between two moves
`define MAZE_STOP_CYCLES 20

// Half period of the countdown blink
`define MAZE_FLASH_CYCLES 5

// Junction decisions kept for the path view
`define MAZE_STACK_DEPTH 16

// Cycle counter of the phase timer
`define MAZE_TIMER_WIDTH 8

// Stack fill level, holds 0 up to the full depth
`define MAZE_DEPTH_WIDTH 5

`endif

//--- hw/mazePkg.sv
`default_nettype none

package mazePkg;

    // Sensor bits {left, mid, right}, 1 means the line is seen
    typedef logic [2:0] road_t;

    typedef enum logic [3:0] {
        IDLE, START, COUNT, STRAIGHT,
        CHOOSE, LEFT, RIGHT, BACK,
        LITTLE_LEFT, LITTLE_RIGHT, STOP, FINISH
    } navState_t;

    typedef enum logic [1:0] {
        DEC_NONE = 2'd0,
        DEC_STRAIGHT = 2'd1,
        DEC_LEFT = 2'd2,
        DEC_RIGHT = 2'd3
    } decision_t;

    typedef enum logic [1:0] {NOP, PUSH, REPLACE} stackOp_t;

    typedef struct packed {stackOp_t op; decision_t value;} stackReq_t;

    // Entry 0 is the top of the stack
    typedef struct packed {
        decision_t entry0;
        decision_t entry1;
        decision_t entry2;
        decision_t entry3;
    } pathView_t;

    typedef struct packed {road_t road; logic run; logic near;} sensorSample_t;

    // Phase 0 countdown, phase 1 stop pause
    typedef struct packed {logic enable; logic phase;} timerReq_t;

    typedef enum logic [1:0] {HALT, FWD, REV} driveDir_t;

    typedef struct packed {driveDir_t leftDir; driveDir_t rightDir;} motorCmd_t;

    typedef struct packed {
        logic [4:0] stateField;
        logic       gapHi;
        logic [5:0] midField;
        logic       gapLo;
        road_t      roadField;
    } ledWord_t;

endpackage

`default_nettype wire

//--- hw/trackInput.sv
`timescale 1ns/100ps
`default_nettype none

module trackInput (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   leftTrack,
    input  logic                   midTrack,
    input  logic                   rightTrack,
    input  logic                   runSwitch,
    input  logic                   obstacleNear,
    output mazePkg::sensorSample_t sample
);

    logic [4:0] pinBits;
    logic [4:0] syncFirst;
    logic [4:0] syncSecond;

    // Same order as the sample struct
    assign pinBits = {leftTrack, midTrack, rightTrack, runSwitch, obstacleNear};

    // All pins are asynchronous to clk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncFirst <= '0;
            syncSecond <= '0;
        end else begin
            syncFirst <= pinBits;
            syncSecond <= syncFirst;
        end
    end

    assign sample.road = syncSecond[4:2];
    assign sample.run = syncSecond[1];
    assign sample.near = syncSecond[0];

endmodule

`default_nettype wire

//--- hw/phaseTimer.sv
`timescale 1ns/100ps
`default_nettype none

`include "mazeRunner_defines.svh"

module phaseTimer (
    input  logic               clk,
    input  logic               rst,
    input  mazePkg::timerReq_t req,
    output logic               timerDone,
    output logic               flash
);

    localparam int TimerWidth = `MAZE_TIMER_WIDTH;
    localparam logic [TimerWidth-1:0] CountLast = TimerWidth'(`MAZE_COUNT_CYCLES - 1);
    localparam logic [TimerWidth-1:0] StopLast = TimerWidth'(`MAZE_STOP_CYCLES - 1);
    localparam logic [TimerWidth-1:0] FlashLast = TimerWidth'(`MAZE_FLASH_CYCLES - 1);

    logic [TimerWidth-1:0] count;
    logic [TimerWidth-1:0] lastCount;
    logic [TimerWidth-1:0] flashCount;

    assign lastCount = req.phase ? StopLast : CountLast;

    // Count saturates at the end, so done stays high until enable drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            flashCount <= '0;
            flash <= 1'b0;
        end else if (!req.enable) begin
            count <= '0;
            flashCount <= '0;
            flash <= 1'b0;
        end else begin
            if (count < lastCount) begin
                count <= count + 1'b1;
            end
            if (flashCount == FlashLast) begin
                flashCount <= '0;
                flash <= ~flash;
            end else begin
                flashCount <= flashCount + 1'b1;
            end
        end
    end

    assign timerDone = req.enable && (count >= lastCount);

endmodule

`default_nettype wire

//--- hw/decisionStack.sv
`timescale 1ns/100ps
`default_nettype none

`include "mazeRunner_defines.svh"

module decisionStack (
    input  logic               clk,
    input  logic               rst,
    input  mazePkg::stackReq_t req,
    output mazePkg::decision_t top,
    output mazePkg::pathView_t path
);

    localparam int DepthWidth = `MAZE_DEPTH_WIDTH;
    localparam int IndexWidth = $clog2(`MAZE_STACK_DEPTH);
    localparam logic [DepthWidth-1:0] DepthMax = DepthWidth'(`MAZE_STACK_DEPTH);

    mazePkg::decision_t entries [`MAZE_STACK_DEPTH];
    mazePkg::decision_t view [4];
    logic [DepthWidth-1:0] depth;
    logic [DepthWidth-1:0] wrIndex;
    logic                  wrEnable;

    // Replace on an empty stack lands in entry 0
    always_comb begin
        wrEnable = 1'b0;
        wrIndex = depth - 1'b1;
        case (req.op)
            mazePkg::PUSH: begin
                wrEnable = (depth != DepthMax);
                wrIndex = depth;
            end
            mazePkg::REPLACE: begin
                wrEnable = 1'b1;
                if (depth == '0) begin
                    wrIndex = '0;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wrEnable) begin
            entries[IndexWidth'(wrIndex)] <= req.value;
        end
    end

    // A write just above the top grows the stack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            depth <= '0;
        end else if (wrEnable && (wrIndex == depth)) begin
            depth <= depth + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (DepthWidth'(i) < depth) begin
                view[i] = entries[IndexWidth'(depth - DepthWidth'(i) - 1'b1)];
            end else begin
                view[i] = mazePkg::DEC_NONE;
            end
        end
    end

    assign path.entry0 = view[0];
    assign path.entry1 = view[1];
    assign path.entry2 = view[2];
    assign path.entry3 = view[3];
    assign top = view[0];

endmodule

`default_nettype wire

//--- hw/mazeNavigator.sv
`timescale 1ns/100ps
`default_nettype none

module mazeNavigator (
    input  logic                   clk,
    input  logic                   rst,
    input  mazePkg::sensorSample_t sample,
    input  logic                   timerDone,
    input  mazePkg::decision_t     top,
    output mazePkg::navState_t     state,
    output mazePkg::timerReq_t     timerReq,
    output mazePkg::stackReq_t     stackReq
);

    mazePkg::navState_t nextState;
    mazePkg::navState_t ruleNext;
    mazePkg::navState_t target;
    mazePkg::navState_t stopTarget;
    mazePkg::stackReq_t ruleReq;
    mazePkg::road_t     road;
    logic               straightFamily;
    logic               rightEntry;
    // Checkpoints, each set once the robot has moved off the marker
    logic               straightSeen;
    logic               chooseSeen;
    logic               leftSeenCross;
    logic               leftSeenTee;
    logic               rightSeen;
    logic [1:0]         rightCount;

    assign road = sample.road;
    assign straightFamily = state inside {mazePkg::STRAIGHT, mazePkg::LITTLE_LEFT,
                                          mazePkg::LITTLE_RIGHT};
    // Fresh arrival on a crossing while turning right
    assign rightEntry = (state == mazePkg::RIGHT) && rightSeen && (road == 3'b111);

    always_comb begin
        ruleNext = state;
        stopTarget = target;
        ruleReq.op = mazePkg::NOP;
        ruleReq.value = mazePkg::DEC_NONE;
        case (state)
            mazePkg::IDLE: if (sample.run) ruleNext = mazePkg::START;
            mazePkg::START: if (road == 3'b010) ruleNext = mazePkg::COUNT;
            mazePkg::COUNT: if (timerDone) ruleNext = mazePkg::STRAIGHT;
            mazePkg::STRAIGHT, mazePkg::LITTLE_LEFT, mazePkg::LITTLE_RIGHT: begin
                case (road)
                    3'b000: begin
                        ruleNext = mazePkg::STOP;
                        stopTarget = mazePkg::BACK;
                    end
                    3'b111: begin
                        if (straightSeen) begin
                            ruleNext = mazePkg::CHOOSE;
                            ruleReq.op = mazePkg::PUSH;
                            ruleReq.value = mazePkg::DEC_STRAIGHT;
                        end else begin
                            ruleNext = mazePkg::STRAIGHT;
                        end
                    end
                    3'b011, 3'b001: ruleNext = mazePkg::LITTLE_RIGHT;
                    3'b110, 3'b100: ruleNext = mazePkg::LITTLE_LEFT;
                    default: ruleNext = mazePkg::STRAIGHT;
                endcase
            end
            mazePkg::CHOOSE: begin
                if (road == 3'b101) begin
                    ruleNext = mazePkg::STOP;
                    stopTarget = mazePkg::LEFT;
                    ruleReq.op = mazePkg::REPLACE;
                    ruleReq.value = mazePkg::DEC_LEFT;
                end else if (road == 3'b111 && chooseSeen) begin
                    ruleNext = mazePkg::STRAIGHT;
                end
            end
            mazePkg::LEFT: begin
                if (road == 3'b101 && leftSeenTee) begin
                    ruleNext = mazePkg::STOP;
                    stopTarget = mazePkg::RIGHT;
                    ruleReq.op = mazePkg::REPLACE;
                    ruleReq.value = mazePkg::DEC_RIGHT;
                end else if (road == 3'b111 && leftSeenCross) begin
                    ruleNext = mazePkg::STOP;
                    stopTarget = mazePkg::STRAIGHT;
                end
            end
            mazePkg::RIGHT: begin
                if (rightEntry && rightCount == 2'd1) begin
                    ruleNext = mazePkg::STOP;
                    stopTarget = mazePkg::STRAIGHT;
                end
            end
            mazePkg::BACK: begin
                if (road == 3'b111) begin
                    ruleNext = mazePkg::STOP;
                    stopTarget = mazePkg::BACK;
                    if (top == mazePkg::DEC_STRAIGHT) begin
                        stopTarget = mazePkg::LEFT;
                        ruleReq.op = mazePkg::REPLACE;
                        ruleReq.value = mazePkg::DEC_LEFT;
                    end else if (top == mazePkg::DEC_LEFT) begin
                        stopTarget = mazePkg::RIGHT;
                        ruleReq.op = mazePkg::REPLACE;
                        ruleReq.value = mazePkg::DEC_RIGHT;
                    end
                end
            end
            mazePkg::STOP: if (timerDone) ruleNext = target;
            default: ;
        endcase

        // Run switch and obstacle win over every state rule
        nextState = ruleNext;
        stackReq = ruleReq;
        if (!sample.run) begin
            nextState = mazePkg::IDLE;
            stackReq.op = mazePkg::NOP;
        end else if (sample.near && state != mazePkg::IDLE) begin
            nextState = mazePkg::FINISH;
            stackReq.op = mazePkg::NOP;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mazePkg::IDLE;
            target <= mazePkg::IDLE;
            straightSeen <= 1'b0;
            chooseSeen <= 1'b0;
            leftSeenCross <= 1'b0;
            leftSeenTee <= 1'b0;
            rightSeen <= 1'b0;
            rightCount <= 2'd0;
        end else begin
            state <= nextState;
            if (nextState == mazePkg::STOP) begin
                target <= stopTarget;
            end

            if ((straightFamily && road != 3'b111) ||
                (state == mazePkg::COUNT && nextState == mazePkg::STRAIGHT)) begin
                straightSeen <= 1'b1;
            end else if (!straightFamily) begin
                straightSeen <= 1'b0;
            end

            chooseSeen <= (state == mazePkg::CHOOSE) && (chooseSeen || road != 3'b111);
            leftSeenCross <= (state == mazePkg::LEFT) && (leftSeenCross || road != 3'b111);
            leftSeenTee <= (state == mazePkg::LEFT) && (leftSeenTee || road != 3'b101);

            // Counting an entry rearms only after leaving the crossing again
            if (state != mazePkg::RIGHT) begin
                rightSeen <= 1'b0;
                rightCount <= 2'd0;
            end else if (road != 3'b111) begin
                rightSeen <= 1'b1;
            end else if (rightEntry) begin
                rightSeen <= 1'b0;
                rightCount <= rightCount + 2'd1;
            end
        end
    end

    assign timerReq.enable = (state == mazePkg::COUNT) || (state == mazePkg::STOP);
    assign timerReq.phase = (state == mazePkg::STOP);

endmodule

`default_nettype wire

//--- hw/statusOutput.sv
`timescale 1ns/100ps
`default_nettype none

module statusOutput (
    input  mazePkg::navState_t state,
    input  mazePkg::road_t     road,
    input  mazePkg::pathView_t path,
    input  logic               flash,
    output mazePkg::ledWord_t  led,
    output mazePkg::motorCmd_t motor
);

    logic [4:0] stateBits;
    logic [5:0] midBits;

    always_comb begin
        stateBits = 5'b00000;
        midBits = 6'b000000;
        motor.leftDir = mazePkg::HALT;
        motor.rightDir = mazePkg::HALT;
        case (state)
            mazePkg::START: stateBits = 5'b00001;
            mazePkg::COUNT: begin
                stateBits = 5'b00010;
                midBits = flash ? 6'b000000 : 6'b111111;
            end
            mazePkg::STRAIGHT, mazePkg::LITTLE_LEFT, mazePkg::LITTLE_RIGHT: begin
                stateBits = 5'b01000;
                midBits = 6'b001100;
                // Small correction stops one wheel
                motor.leftDir = (state == mazePkg::LITTLE_LEFT) ? mazePkg::HALT : mazePkg::FWD;
                motor.rightDir = (state == mazePkg::LITTLE_RIGHT) ? mazePkg::HALT : mazePkg::FWD;
            end
            mazePkg::CHOOSE: stateBits = 5'b00100;
            mazePkg::LEFT, mazePkg::BACK: begin
                stateBits = (state == mazePkg::LEFT) ? 5'b10000 : 5'b01010;
                midBits = (state == mazePkg::LEFT) ? 6'b110000 : 6'b000000;
                motor.leftDir = mazePkg::REV;
                motor.rightDir = mazePkg::FWD;
            end
            mazePkg::RIGHT: begin
                stateBits = 5'b00100;
                midBits = 6'b000011;
                motor.leftDir = mazePkg::FWD;
                motor.rightDir = mazePkg::REV;
            end
            mazePkg::STOP: begin
                stateBits = 5'b11100;
                midBits = 6'b111111;
            end
            default: ;
        endcase

        // Finish shows the recorded decisions, top entry leftmost
        if (state == mazePkg::FINISH) begin
            led = mazePkg::ledWord_t'({path, 8'hFF});
        end else begin
            led = mazePkg::ledWord_t'({stateBits, 1'b0, midBits, 1'b0, road});
        end
    end

endmodule

`default_nettype wire

//--- hw/mazeRunner.sv
`timescale 1ns/100ps
`default_nettype none

module mazeRunner (
    input  logic               clk,
    input  logic               rst,
    input  logic               leftTrack,
    input  logic               midTrack,
    input  logic               rightTrack,
    input  logic               runSwitch,
    input  logic               obstacleNear,
    output mazePkg::ledWord_t  led,
    output mazePkg::motorCmd_t motor
);

    mazePkg::sensorSample_t sample;
    mazePkg::navState_t     state;
    mazePkg::timerReq_t     timerReq;
    mazePkg::stackReq_t     stackReq;
    mazePkg::decision_t     stackTop;
    mazePkg::pathView_t     path;
    logic                   timerDone;
    logic                   flash;

    trackInput trackInput_i (.clk, .rst, .leftTrack, .midTrack, .rightTrack, .runSwitch,
                             .obstacleNear, .sample);

    mazeNavigator mazeNavigator_i (.clk, .rst, .sample, .timerDone, .top(stackTop), .state,
                                   .timerReq, .stackReq);

    phaseTimer phaseTimer_i (.clk, .rst, .req(timerReq), .timerDone, .flash);

    decisionStack decisionStack_i (.clk, .rst, .req(stackReq), .top(stackTop), .path);

    statusOutput statusOutput_i (.state, .road(sample.road), .path, .flash, .led, .motor);

endmodule

`default_nettype wire

//--- verif/mazeRunnerTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mazeRunner_defines.svh"

module mazeRunnerTb;

    localparam int NameBits = 8 * 24;
    localparam int ResetCycles = 5;
    localparam int MinTests = 22;
    localparam int MaxLines = 200;
    // Longest hold allowed for one vector
    localparam int MaxHold = 4 * `MAZE_COUNT_CYCLES;

    logic               clk;
    logic               rst;
    logic               leftTrack;
    logic               midTrack;
    logic               rightTrack;
    logic               runSwitch;
    logic               obstacleNear;
    mazePkg::ledWord_t  led;
    mazePkg::motorCmd_t motor;

    int                 fd;
    int                 lineCount;
    int                 testCount;
    int                 passCount;
    int                 failCount;
    int                 cycle;
    logic               testOk;
    string              lineText;

    mazeRunner mazeRunner_i (.clk, .rst, .leftTrack, .midTrack, .rightTrack, .runSwitch,
                             .obstacleNear, .led, .motor);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic checkLed(input logic [NameBits-1:0] name, input mazePkg::ledWord_t expected,
                            input mazePkg::ledWord_t actual, input logic maskMid);
        mazePkg::ledWord_t expView;
        mazePkg::ledWord_t actView;
        expView = expected;
        actView = actual;
        if (maskMid) begin
            expView.midField = '0;
            actView.midField = '0;
        end
        if (actView !== expView) begin
            $display("FAILED %0s led expected %h actual %h", name, expected, actual);
            testOk = 1'b0;
        end
    endtask

    task automatic checkDrive(input logic [NameBits-1:0] name,
                              input mazePkg::motorCmd_t expected,
                              input mazePkg::motorCmd_t actual);
        if (actual !== expected) begin
            $display("FAILED %0s motor expected %h actual %h", name, expected, actual);
            testOk = 1'b0;
        end
    endtask

    task automatic holdCycles(input int cycles);
        int limit;
        int i;
        limit = cycles;
        if (cycles > MaxHold) begin
            $display("Hold of %0d cycles is over the limit of %0d", cycles, MaxHold);
            testOk = 1'b0;
            limit = MaxHold;
        end
        for (i = 0; i < limit; i++) begin
            @(posedge clk);
        end
    endtask

    // One vector: drive, hold, then compare away from the clock edge
    task automatic runVector(input string text);
        logic [NameBits-1:0] name;
        int                  runVal;
        int                  nearVal;
        int                  leftVal;
        int                  midVal;
        int                  rightVal;
        int                  hold;
        int                  maskVal;
        int                  fields;
        logic [15:0]         ledHex;
        logic [3:0]          motorHex;
        fields = $sscanf(text, "%s %d %d %d %d %d %d %h %h %d", name, runVal, nearVal,
                         leftVal, midVal, rightVal, hold, ledHex, motorHex, maskVal);
        if (fields != 10) begin
            $display("Stimulus line could not be read: %0s", text);
            failCount++;
            return;
        end
        testCount++;
        testOk = 1'b1;
        @(posedge clk);
        runSwitch <= (runVal != 0);
        obstacleNear <= (nearVal != 0);
        leftTrack <= (leftVal != 0);
        midTrack <= (midVal != 0);
        rightTrack <= (rightVal != 0);
        holdCycles(hold);
        @(negedge clk);
        checkLed(name, mazePkg::ledWord_t'(ledHex), led, (maskVal != 0));
        checkDrive(name, mazePkg::motorCmd_t'(motorHex), motor);
        if (testOk) begin
            $display("passed %0s", name);
            passCount++;
        end else begin
            failCount++;
        end
    endtask

    initial begin
        rst = 1'b1;
        leftTrack = 1'b0;
        midTrack = 1'b0;
        rightTrack = 1'b0;
        runSwitch = 1'b0;
        obstacleNear = 1'b0;
        testCount = 0;
        passCount = 0;
        failCount = 0;
        lineCount = 0;
        for (cycle = 0; cycle < ResetCycles; cycle++) begin
            @(posedge clk);
        end
        rst <= 1'b0;

        fd = $fopen("verif/mazeInput.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file verif/mazeInput.txt");
            failCount++;
        end else begin
            while (!$feof(fd) && lineCount < MaxLines) begin
                lineText = "";
                lineCount++;
                if ($fgets(lineText, fd) != 0) begin
                    if (lineText.len() > 1 && lineText.getc(0) != "#") begin
                        runVector(lineText);
                    end
                end
            end
            $fclose(fd);
            if (testCount < MinTests) begin
                $display("Stimulus file holds %0d tests, expected %0d", testCount, MinTests);
                failCount++;
            end
        end

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mazeRunner.f
+incdir+hw
hw/mazePkg.sv
hw/trackInput.sv
hw/phaseTimer.sv
hw/decisionStack.sv
hw/mazeNavigator.sv
hw/statusOutput.sv
hw/mazeRunner.sv
verif/mazeRunnerTb.sv

//--- run.sh
#!/bin/sh
# Compile the maze runner testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -f mazeRunner.f --top-module mazeRunnerTb \
    -Mdir "$BUILD_DIR" -o mazeRunnerSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/mazeRunnerSim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG_FILE"; then
    exit 0
fi
exit 1

//--- verif/mazeInput.txt
# name run near left mid right holdCycles expectedLed(hex) expectedMotor(hex) maskMid
# maskMid 1 ignores led bits 9:4 where the countdown flash is running
resetIdle 0 0 0 1 0 8 0002 0 0
startWait 1 0 0 0 0 8 0800 0 0
countdown 1 0 0 1 0 8 1002 0 1
straightRun 1 0 0 1 0 45 40C2 5 0
littleLeft 1 0 1 1 0 8 40C6 1 0
littleRight 1 0 0 1 1 8 40C3 4 0
junction 1 0 1 1 1 8 2007 0 0
chooseTee 1 0 1 0 1 8 E3F5 0 0
turnLeft 1 0 1 0 1 25 8305 9 0
leftCross 1 0 1 1 1 8 E3F7 0 0
crossStraight 1 0 0 1 0 25 40C2 5 0
junctionAgain 1 0 1 1 1 8 2007 0 0
chooseClear 1 0 0 1 0 8 2002 0 0
chooseAhead 1 0 1 1 1 8 40C7 5 0
deadEnd 1 0 0 0 0 8 E3F0 0 0
backTurn 1 0 0 0 0 25 5000 9 0
backCross 1 0 1 1 1 8 E3F7 0 0
retryLeft 1 0 0 1 0 25 8302 9 0
leftTee 1 0 1 0 1 8 E3F5 0 0
turnRight 1 0 1 0 1 25 2035 6 0
obstacle 1 1 0 1 0 8 E0FF 0 0
runOff 0 0 0 1 0 8 0002 0 0
